//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// width of a register and of an instruction word.
`define XLEN 32

// architectural registers, addressed by 5 bits.
`define REG_COUNT 32

// instruction queue entries, which is also the sender's starting credit count.
`define QUEUE_DEPTH 2

`endif

//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // major opcodes of RV32I. only opc_op and opc_op_imm are executed here.
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    // low three bits follow funct3, bit 3 is funct7 bit 30.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/instruction_queue.sv
`default_nettype none

`include "core_settings.svh"

module instruction_queue #(
    parameter int depth = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic [`XLEN-1:0]  push_data,
    input  logic              pop,
    output logic              valid,
    output logic [`XLEN-1:0]  data,
    output logic              credit_return
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);
    localparam logic [ptr_width-1:0] last_ptr = ptr_width'(depth - 1);

    logic [`XLEN-1:0]       storage [depth];
    logic [ptr_width-1:0]   write_ptr;
    logic [ptr_width-1:0]   read_ptr;
    logic [count_width-1:0] count;
    logic                   do_pop;

    assign valid = (count != '0);
    assign data = storage[read_ptr];
    assign do_pop = pop & valid; // a pop on an empty queue is ignored.

    always_ff @(posedge clk) begin
        if (push) begin
            storage[write_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop; // one credit back per entry that leaves.
            if (push) begin
                write_ptr <= (write_ptr == last_ptr) ? '0 : write_ptr + 1'b1;
            end
            if (do_pop) begin
                read_ptr <= (read_ptr == last_ptr) ? '0 : read_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

`include "core_settings.svh"

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              write_enable,
    input  logic [4:0]        write_address,
    input  logic [`XLEN-1:0]  write_data,
    input  logic [4:0]        read_address_a,
    input  logic [4:0]        read_address_b,
    output logic [`XLEN-1:0]  read_data_a,
    output logic [`XLEN-1:0]  read_data_b
);

    logic [`XLEN-1:0] registers [`REG_COUNT];

    // each register comes out of reset holding its own index.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= `XLEN'(i);
            end
        end else if (write_enable && (write_address != 5'd0)) begin
            registers[write_address] <= write_data; // x0 is never written.
        end
    end

    // reads see the state before this edge's write.
    assign read_data_a = registers[read_address_a];
    assign read_data_b = registers[read_address_b];

endmodule

`default_nettype wire

//--- verilog/instruction_decoder.sv
`default_nettype none

`include "core_settings.svh"

module instruction_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              queue_valid,
    input  logic [`XLEN-1:0]  queue_instr,
    output logic              queue_pop,
    output logic [4:0]        read_address_a,
    output logic [4:0]        read_address_b,
    input  logic [`XLEN-1:0]  read_data_a,
    input  logic [`XLEN-1:0]  read_data_b,
    input  logic              mem_write,
    input  logic [4:0]        mem_rd,
    input  logic [`XLEN-1:0]  mem_data,
    output logic              id_valid,
    output logic              id_write,
    output logic [4:0]        id_rd,
    output logic [4:0]        id_rs1,
    output logic [4:0]        id_rs2,
    output alu_pkg::alu_op_e  id_op,
    output logic              id_use_imm,
    output logic [`XLEN-1:0]  id_imm,
    output logic [`XLEN-1:0]  id_operand_a,
    output logic [`XLEN-1:0]  id_operand_b
);

    import alu_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic             funct7_b30;
    logic [4:0]       rd;
    logic             is_op;
    logic             is_op_imm;
    logic             is_shift;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;

    assign queue_pop = queue_valid; // no stalls, so every entry leaves at once.

    assign opcode = opcode_e'(queue_instr[6:0]);
    assign rd = queue_instr[11:7];
    assign funct3 = queue_instr[14:12];
    assign read_address_a = queue_instr[19:15];
    assign read_address_b = queue_instr[24:20];
    assign funct7_b30 = queue_instr[30];

    assign is_op = (opcode == opc_op);
    assign is_op_imm = (opcode == opc_op_imm);
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && funct7_b30) ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = funct7_b30 ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

    // shift immediates carry only the shift amount.
    assign imm = is_shift ? {{(`XLEN-5){1'b0}}, queue_instr[24:20]}
                          : {{(`XLEN-12){queue_instr[31]}}, queue_instr[31:20]};

    // the value being written this cycle is not yet in the register file.
    assign operand_a = (mem_write && (mem_rd == read_address_a)) ? mem_data : read_data_a;
    assign operand_b = (mem_write && (mem_rd == read_address_b)) ? mem_data : read_data_b;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_write <= 1'b0;
        end else begin
            id_valid <= queue_valid;
            id_write <= queue_valid && (is_op || is_op_imm) && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (queue_valid) begin
            id_rd <= rd;
            id_rs1 <= read_address_a;
            id_rs2 <= read_address_b;
            id_op <= alu_op;
            id_use_imm <= is_op_imm;
            id_imm <= imm;
            id_operand_a <= operand_a;
            id_operand_b <= operand_b;
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

`include "core_settings.svh"

module alu (
    input  alu_pkg::alu_op_e  op,
    input  logic [`XLEN-1:0]  operand_a,
    input  logic [`XLEN-1:0]  operand_b,
    output logic [`XLEN-1:0]  result
);

    import alu_pkg::*;

    logic [4:0] shift_amount;
    logic       less_signed;
    logic       less_unsigned;

    assign shift_amount = operand_b[4:0];
    assign less_signed = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;

    always_comb begin
        case (op)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_sll:  result = operand_a << shift_amount;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, less_signed};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, less_unsigned};
            alu_xor:  result = operand_a ^ operand_b;
            alu_srl:  result = operand_a >> shift_amount;
            alu_sra:  result = $signed(operand_a) >>> shift_amount; // fills with the sign bit.
            alu_or:   result = operand_a | operand_b;
            alu_and:  result = operand_a & operand_b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

`include "core_settings.svh"

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              id_valid,
    input  logic              id_write,
    input  logic [4:0]        id_rd,
    input  logic [4:0]        id_rs1,
    input  logic [4:0]        id_rs2,
    input  alu_pkg::alu_op_e  id_op,
    input  logic              id_use_imm,
    input  logic [`XLEN-1:0]  id_imm,
    input  logic [`XLEN-1:0]  id_operand_a,
    input  logic [`XLEN-1:0]  id_operand_b,
    output logic              mem_write,
    output logic [4:0]        mem_rd,
    output logic [`XLEN-1:0]  mem_data
);

    import alu_pkg::*;

    logic [`XLEN-1:0] forward_a;
    logic [`XLEN-1:0] forward_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;

    // the instruction one ahead has its result only in the EX/MEM register.
    assign forward_a = (mem_write && (mem_rd == id_rs1)) ? mem_data : id_operand_a;
    assign forward_b = (mem_write && (mem_rd == id_rs2)) ? mem_data : id_operand_b;
    assign alu_b = id_use_imm ? id_imm : forward_b;

    alu i_alu (
        .op        (id_op),
        .operand_a (forward_a),
        .operand_b (alu_b),
        .result    (alu_result)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_write <= 1'b0;
        end else begin
            mem_write <= id_valid && id_write;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            mem_rd <= id_rd;
            mem_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_core.sv
`default_nettype none

`include "core_settings.svh"

module alu_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [`XLEN-1:0]  instr,
    output logic              credit_return,
    output logic              retire_valid,
    output logic [4:0]        retire_rd,
    output logic [`XLEN-1:0]  retire_data
);

    import alu_pkg::*;

    logic             queue_valid;
    logic [`XLEN-1:0] queue_instr;
    logic             queue_pop;
    logic [4:0]       read_address_a;
    logic [4:0]       read_address_b;
    logic [`XLEN-1:0] read_data_a;
    logic [`XLEN-1:0] read_data_b;
    logic             id_valid;
    logic             id_write;
    logic [4:0]       id_rd;
    logic [4:0]       id_rs1;
    logic [4:0]       id_rs2;
    alu_op_e          id_op;
    logic             id_use_imm;
    logic [`XLEN-1:0] id_imm;
    logic [`XLEN-1:0] id_operand_a;
    logic [`XLEN-1:0] id_operand_b;
    logic             mem_write;
    logic [4:0]       mem_rd;
    logic [`XLEN-1:0] mem_data;

    // every register write is also a retirement.
    assign retire_valid = mem_write;
    assign retire_rd = mem_rd;
    assign retire_data = mem_data;

    instruction_queue #(
        .depth (`QUEUE_DEPTH)
    ) i_instruction_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (instr_valid),
        .push_data     (instr),
        .pop           (queue_pop),
        .valid         (queue_valid),
        .data          (queue_instr),
        .credit_return (credit_return)
    );

    instruction_decoder i_instruction_decoder (
        .clk            (clk),
        .reset          (reset),
        .queue_valid    (queue_valid),
        .queue_instr    (queue_instr),
        .queue_pop      (queue_pop),
        .read_address_a (read_address_a),
        .read_address_b (read_address_b),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b),
        .mem_write      (mem_write),
        .mem_rd         (mem_rd),
        .mem_data       (mem_data),
        .id_valid       (id_valid),
        .id_write       (id_write),
        .id_rd          (id_rd),
        .id_rs1         (id_rs1),
        .id_rs2         (id_rs2),
        .id_op          (id_op),
        .id_use_imm     (id_use_imm),
        .id_imm         (id_imm),
        .id_operand_a   (id_operand_a),
        .id_operand_b   (id_operand_b)
    );

    register_file i_register_file (
        .clk            (clk),
        .reset          (reset),
        .write_enable   (mem_write),
        .write_address  (mem_rd),
        .write_data     (mem_data),
        .read_address_a (read_address_a),
        .read_address_b (read_address_b),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .id_valid     (id_valid),
        .id_write     (id_write),
        .id_rd        (id_rd),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_op        (id_op),
        .id_use_imm   (id_use_imm),
        .id_imm       (id_imm),
        .id_operand_a (id_operand_a),
        .id_operand_b (id_operand_b),
        .mem_write    (mem_write),
        .mem_rd       (mem_rd),
        .mem_data     (mem_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int period = 8
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset covers the first three rising edges.
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/alu_core_tb.sv
`default_nettype none

`include "core_settings.svh"

module alu_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 8;
    localparam int max_lines = 64;
    localparam logic [75:0] empty_line = '1;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    logic [`XLEN-1:0]  instr;
    logic              credit_return;
    logic              retire_valid;
    logic [4:0]        retire_rd;
    logic [`XLEN-1:0]  retire_data;

    logic [75:0] stimulus [max_lines]; // instruction, retire flag, rd, value.
    int          line_count;
    int          retire_lines [$];
    int          retired;
    int          credits;

    tb_clock #(
        .period (clk_period)
    ) i_clock (
        .clk   (clk),
        .reset (reset)
    );

    alu_core i_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .credit_return (credit_return),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_stimulus();
        for (int i = 0; i < max_lines; i++) begin
            stimulus[i] = empty_line;
        end
        $readmemh("bench/alu_core_stimulus.txt", stimulus);
        line_count = 0;
        while (line_count < max_lines && stimulus[line_count] != empty_line) begin
            if (stimulus[line_count][43:40] != 4'h0) begin
                retire_lines.push_back(line_count); // only these lines expect a retirement.
            end
            line_count++;
        end
    endtask

    task automatic drive_instructions();
        int gap;
        @(negedge reset);
        @(posedge clk);
        #1;
        for (int i = 0; i < line_count; i++) begin
            gap = int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            while (credits == 0) begin
                @(posedge clk);
                #1;
            end
            instr_valid = 1'b1;
            instr = stimulus[i][75:44];
            credits--;
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled.
    task automatic watch_retirements();
        logic [75:0] line;
        forever begin
            @(negedge clk);
            if (credit_return) begin
                credits++;
                check_value("credit count within depth", 32'(credits <= `QUEUE_DEPTH), 32'd1);
            end
            if (retire_valid && retired >= retire_lines.size()) begin
                $display("Checks failed");
                $fatal(1, "retirement of x%0d with no instruction left to retire", retire_rd);
            end else if (retire_valid) begin
                line = stimulus[retire_lines[retired]];
                check_value("retire_rd", 32'(retire_rd), 32'(line[39:32]));
                check_value("retire_data", retire_data, line[31:0]);
                retired++;
            end
        end
    endtask

    task automatic run_watchdog();
        #((line_count * 8 + 50) * clk_period);
        $display("Checks failed");
        $fatal(1, "timeout, the run did not finish in %0d clock periods", line_count * 8 + 50);
    endtask

    initial begin
        instr_valid = 1'b0;
        instr = '0;
        retired = 0;
        credits = `QUEUE_DEPTH;
        void'($urandom(32'h05358ce1));
        load_stimulus();
        fork
            run_watchdog();
            watch_retirements();
            begin
                drive_instructions();
                wait (retired == retire_lines.size());
                repeat (4) @(negedge clk); // the pipeline drains in fewer cycles than this.
                check_value("final credit count", 32'(credits), 32'(`QUEUE_DEPTH));
            end
        join_any
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/alu_core_stimulus.txt
// instruction _ retire flag _ expected rd _ expected value, all in hex.
// registers start at their own index; a flag of 0 means no retirement is expected.
00008093_1_01_00000001
00088893_1_11_00000011
000f8f93_1_1f_0000001f
00728013_0_00_00000000
ffb18113_1_02_fffffffe
fff12213_1_04_00000001
fff3b313_1_06_00000001
0f04c413_1_08_000000f9
f005e513_1_0a_ffffff0b
07f57613_1_0c_0000000b
00411693_1_0d_ffffffe0
0046d713_1_0e_0ffffffe
4046d793_1_0f_fffffffe
00c50833_1_10_ffffff16
40a60933_1_12_00000100
010499b3_1_13_02400000
00c52ab3_1_15_00000001
00c53b33_1_16_00000000
01854bb3_1_17_ffffff13
01a55cb3_1_19_0000003f
40355db3_1_1b_ffffffe1
01d66e33_1_1c_0000001f
01f57f33_1_1e_0000000b
06428293_1_05_00000069
005283b3_1_07_000000d2
405384b3_1_09_00000069
0074c5b3_1_0b_000000bb
001121a3_0_00_00000000
00108263_0_00_00000000
00018a13_1_14_00000003
00020a93_1_15_00000001

//--- alu_core.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/instruction_queue.sv
verilog/register_file.sv
verilog/instruction_decoder.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/alu_core.sv
bench/tb_clock.sv
bench/alu_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing -j 0 --top-module alu_core_tb \
    -f alu_core.f -Mdir "$build_dir" -o alu_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$build_dir/alu_core_sim"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
